/* cc_offload.f */
hdl/cc_offload_pkg.sv
hdl/acc_stream_if.sv
hdl/offload_router.sv
hdl/ssr_cfg_decode.sv
hdl/ssr_cfg_ctrl.sv
hdl/ssr_cfg_regs.sv
hdl/cc_offload.sv
testbench/tb_cc_offload.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the offload fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cc_offload \
  -f cc_offload.f > sim.log 2>&1 &&
  ./obj_dir/Vtb_cc_offload >> sim.log 2>&1 ||
  { cat sim.log; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/tb_cc_offload.sv */
// Offload fabric testbench
// Drives core offload requests, models the FPU and muldiv units and
// checks routing, SSR config accesses and response arbitration

`timescale 1ns/1ps
`default_nettype none

module tb_cc_offload;

  localparam int unsigned max_wait_cycles = 200;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    acc_qvalid_i;
  cc_offload_pkg::target_t acc_qtarget_i;
  cc_offload_pkg::id_t     acc_qid_i;
  cc_offload_pkg::instr_t  acc_qop_i;
  cc_offload_pkg::data_t   acc_qarga_i;
  cc_offload_pkg::data_t   acc_qargb_i;
  logic                    acc_qready_o;
  logic                    acc_pvalid_o;
  cc_offload_pkg::id_t     acc_pid_o;
  cc_offload_pkg::data_t   acc_pdata_o;
  logic                    acc_perror_o;
  logic                    acc_pready_i;
  cc_offload_pkg::id_t     ext_qid_o;
  cc_offload_pkg::instr_t  ext_qop_o;
  cc_offload_pkg::data_t   ext_qarga_o;
  cc_offload_pkg::data_t   ext_qargb_o;
  logic                    fpu_qvalid_o;
  logic                    mdu_qvalid_o;
  logic                    fpu_pready_o;
  logic                    mdu_pready_o;

  // External unit models with index 0 the FPU and 1 muldiv
  logic                    ext_qready [2];
  logic                    ext_pvalid [2];
  cc_offload_pkg::id_t     ext_pid    [2];
  cc_offload_pkg::data_t   ext_pdata  [2];
  logic                    ext_perror [2];
  logic                    ext_taken  [2];
  int unsigned             ext_rate;
  int unsigned             pready_rate;

  // Reference copy of the config bank and expected SSR responses
  cc_offload_pkg::data_t bank [cc_offload_pkg::NumDataMovers][cc_offload_pkg::NumCfgRegs];
  cc_offload_pkg::id_t   exp_id_q   [$];
  cc_offload_pkg::data_t exp_data_q [$];
  logic [2:0]            seen [3];
  int unsigned           errors;
  int unsigned           timeouts;
  logic                  payload_ok;

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  cc_offload u_cc_offload (
    .fpu_qready_i (ext_qready[0]),
    .mdu_qready_i (ext_qready[1]),
    .fpu_pvalid_i (ext_pvalid[0]),
    .fpu_pid_i    (ext_pid[0]),
    .fpu_pdata_i  (ext_pdata[0]),
    .fpu_perror_i (ext_perror[0]),
    .mdu_pvalid_i (ext_pvalid[1]),
    .mdu_pid_i    (ext_pid[1]),
    .mdu_pdata_i  (ext_pdata[1]),
    .mdu_perror_i (ext_perror[1]),
    .*
  );

  task automatic report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  // Holds the request until the selected target takes it
  task automatic send_req(input cc_offload_pkg::target_t tgt, input cc_offload_pkg::id_t id,
                          input cc_offload_pkg::instr_t op, input cc_offload_pkg::data_t arga,
                          input cc_offload_pkg::data_t argb, output logic ok);
    int unsigned waited;
    waited        = 0;
    acc_qvalid_i  = 1'b1;
    acc_qtarget_i = tgt;
    acc_qid_i     = id;
    acc_qop_i     = op;
    acc_qarga_i   = arga;
    acc_qargb_i   = argb;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!acc_qready_o && waited < max_wait_cycles);
    ok = acc_qready_o;
    if (!ok) begin
      timeouts++;
      $display("Timeout at %0t: target %0d never accepted the request", $time, tgt);
    end
    @(negedge clk_i);
    acc_qvalid_i = 1'b0;
  endtask

  // One scfg access with register in raw [11:5] and data mover in raw [4:0]
  task automatic ssr_access(input logic write, input logic imm, input logic [11:0] raw,
                            input cc_offload_pkg::data_t wdata, input cc_offload_pkg::id_t id);
    cc_offload_pkg::instr_t op;
    cc_offload_pkg::data_t  argb;
    cc_offload_pkg::data_t  old;
    logic                   in_bank;
    logic                   ok;
    op   = $urandom;
    argb = $urandom;
    if (imm) begin
      op[31:20] = raw;
    end else begin
      argb[11:0] = raw;
    end
    op[14:12] = write ? (imm ? cc_offload_pkg::ScfgFunct3Wi : cc_offload_pkg::ScfgFunct3W)
                      : (imm ? cc_offload_pkg::ScfgFunct3Ri : cc_offload_pkg::ScfgFunct3R);
    op[6:0]   = cc_offload_pkg::ScfgOpcode;
    in_bank   = (raw[4:0] < cc_offload_pkg::NumDataMovers) &&
                (raw[11:5] < cc_offload_pkg::NumCfgRegs);
    old       = in_bank ? bank[raw[4:0]][raw[11:5]] : '0;
    send_req(2'd2, id, op, wdata, argb, ok);
    if (ok) begin
      exp_id_q.push_back(write ? '0 : id);
      exp_data_q.push_back(old);
      if (write && in_bank) begin
        bank[raw[4:0]][raw[11:5]] = wdata;
      end
    end
  endtask

  function automatic logic [11:0] pick_raw();
    logic [11:0] raw;
    // Mostly inside the bank and now and then beyond it
    raw[4:0]  = ($urandom % 4 == 0) ? 5'($urandom) : 5'($urandom % cc_offload_pkg::NumDataMovers);
    raw[11:5] = ($urandom % 4 == 0) ? 7'($urandom) : 7'($urandom % cc_offload_pkg::NumCfgRegs);
    return raw;
  endfunction

  // ------------------------------------------------------------
  // External units and core response ready
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    ext_taken[0] <= ext_pvalid[0] && fpu_pready_o;
    ext_taken[1] <= ext_pvalid[1] && mdu_pready_o;
  end

  always @(negedge clk_i) begin
    if (rst_ni) begin
      acc_pready_i = ($urandom % 100) < pready_rate;
      for (int u = 0; u < 2; u++) begin
        ext_qready[u] = ($urandom % 100) < 60;
        // A response holds until taken and a new one may follow at once
        if (ext_taken[u] || !ext_pvalid[u]) begin
          ext_pvalid[u] = ($urandom % 100) < ext_rate;
          ext_pid[u]    = cc_offload_pkg::id_t'($urandom);
          ext_pdata[u]  = $urandom;
          ext_perror[u] = 1'($urandom);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  assign payload_ok = ext_qid_o == acc_qid_i && ext_qop_o == acc_qop_i &&
                      ext_qarga_o == acc_qarga_i && ext_qargb_o == acc_qargb_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_qvalid_i && acc_qtarget_i == 2'd0 |->
      fpu_qvalid_o && !mdu_qvalid_o && acc_qready_o == ext_qready[0] && payload_ok)
    else report_mismatch("FPU request routing");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_qvalid_i && acc_qtarget_i == 2'd1 |->
      mdu_qvalid_o && !fpu_qvalid_o && acc_qready_o == ext_qready[1] && payload_ok)
    else report_mismatch("muldiv request routing");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(acc_qvalid_i && acc_qtarget_i < 2'd2) |-> !fpu_qvalid_o && !mdu_qvalid_o)
    else report_mismatch("external valid without a request for it");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_qvalid_i && acc_qtarget_i == 2'd3 |-> !acc_qready_o)
    else report_mismatch("unused target got ready");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_pvalid_o && !acc_pready_i |=> acc_pvalid_o && $stable(acc_pid_o) &&
      $stable(acc_pdata_o) && $stable(acc_perror_o))
    else report_mismatch("response changed under back-pressure");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fpu_pready_o || mdu_pready_o |-> acc_pready_i && !(fpu_pready_o && mdu_pready_o))
    else report_mismatch("external response ready without core ready or to both units");

  // Response scoreboard and round-robin fairness
  always @(posedge clk_i) begin
    int unsigned           g;
    logic [2:0]            v;
    cc_offload_pkg::id_t   eid;
    cc_offload_pkg::data_t edata;
    logic                  eerr;
    if (rst_ni && acc_pvalid_o && acc_pready_i) begin
      v = {exp_id_q.size() != 0, ext_pvalid[1], ext_pvalid[0]};
      g = fpu_pready_o ? 0 : (mdu_pready_o ? 1 : 2);
      assert (v[g])
        else report_mismatch($sformatf("source %0d answered with nothing waiting", g));
      if (v[g]) begin
        eid   = (g == 2) ? exp_id_q.pop_front() : ext_pid[g];
        edata = (g == 2) ? exp_data_q.pop_front() : ext_pdata[g];
        eerr  = (g == 2) ? 1'b0 : ext_perror[g];
        assert (acc_pid_o == eid && acc_pdata_o == edata && acc_perror_o == eerr)
          else report_mismatch($sformatf("source %0d gave id %0h data %h err %b, exp %0h %h %b",
                                         g, acc_pid_o, acc_pdata_o, acc_perror_o,
                                         eid, edata, eerr));
      end
      for (int j = 0; j < 3; j++) begin
        if (j == g || !v[j]) begin
          seen[j] = '0;
        end else begin
          assert (!seen[j][g])
            else report_mismatch($sformatf("source %0d granted twice while %0d waits", g, j));
          seen[j][g] = 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    logic        ok;
    logic        imm;
    logic [11:0] raw;
    int unsigned waited;
    void'($urandom(32'h249f_8b5b));
    rst_ni        = 1'b0;
    acc_qvalid_i  = 1'b0;
    acc_qtarget_i = '0;
    acc_qid_i     = '0;
    acc_qop_i     = '0;
    acc_qarga_i   = '0;
    acc_qargb_i   = '0;
    acc_pready_i  = 1'b1;
    ext_rate      = 0;
    pready_rate   = 100;
    errors        = 0;
    timeouts      = 0;
    for (int u = 0; u < 3; u++) begin
      seen[u] = '0;
    end
    for (int u = 0; u < 2; u++) begin
      ext_qready[u] = 1'b0;
      ext_pvalid[u] = 1'b0;
      ext_pid[u]    = '0;
      ext_pdata[u]  = '0;
      ext_perror[u] = 1'b0;
      ext_taken[u]  = 1'b0;
    end
    for (int dm = 0; dm < cc_offload_pkg::NumDataMovers; dm++) begin
      for (int r = 0; r < cc_offload_pkg::NumCfgRegs; r++) begin
        bank[dm][r] = '0;
      end
    end

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!acc_pvalid_o && !fpu_qvalid_o && !mdu_qvalid_o)
      else report_mismatch("valid outputs active after reset");
    ext_rate    = 30;
    pready_rate = 70;

    // Requests for the FPU and muldiv ports
    repeat (30) begin
      send_req(cc_offload_pkg::target_t'($urandom % 2), cc_offload_pkg::id_t'($urandom),
               $urandom, $urandom, $urandom, ok);
    end
    // Target 3 stays stalled
    acc_qvalid_i  = 1'b1;
    acc_qtarget_i = 2'd3;
    repeat (4) @(negedge clk_i);
    acc_qvalid_i  = 1'b0;

    // Write and then read back through the other form
    repeat (40) begin
      raw = pick_raw();
      imm = 1'($urandom);
      ssr_access(1'b1, imm, raw, $urandom, cc_offload_pkg::id_t'($urandom));
      ssr_access(1'b0, !imm, raw, '0, cc_offload_pkg::id_t'($urandom));
    end

    // All three sources busy at once
    ext_rate    = 100;
    pready_rate = 50;
    repeat (40) begin
      ssr_access(1'b0, 1'($urandom), pick_raw(), '0, cc_offload_pkg::id_t'($urandom));
    end

    ext_rate    = 0;
    pready_rate = 100;
    waited      = 0;
    while ((exp_id_q.size() != 0 || ext_pvalid[0] || ext_pvalid[1]) &&
           waited < max_wait_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_id_q.size() != 0 || ext_pvalid[0] || ext_pvalid[1]) begin
      timeouts++;
      $display("Timeout at %0t: responses never drained, %0d of them from the SSR unit",
               $time, exp_id_q.size());
    end

    $display("Closing counts: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/cc_offload.sv */
// Core complex offload fabric
// Routes core offload requests to FPU, muldiv or the SSR config unit
// and merges their responses back to the core

`timescale 1ns/1ps
`default_nettype none

module cc_offload (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Core request
  input  wire logic                    acc_qvalid_i,
  input  wire cc_offload_pkg::target_t acc_qtarget_i,
  input  wire cc_offload_pkg::id_t     acc_qid_i,
  input  wire cc_offload_pkg::instr_t  acc_qop_i,
  input  wire cc_offload_pkg::data_t   acc_qarga_i,
  input  wire cc_offload_pkg::data_t   acc_qargb_i,
  output logic                         acc_qready_o,
  // Core response
  output logic                         acc_pvalid_o,
  output cc_offload_pkg::id_t          acc_pid_o,
  output cc_offload_pkg::data_t        acc_pdata_o,
  output logic                         acc_perror_o,
  input  wire logic                    acc_pready_i,
  // Shared external request payload
  output cc_offload_pkg::id_t          ext_qid_o,
  output cc_offload_pkg::instr_t       ext_qop_o,
  output cc_offload_pkg::data_t        ext_qarga_o,
  output cc_offload_pkg::data_t        ext_qargb_o,
  output logic                         fpu_qvalid_o,
  input  wire logic                    fpu_qready_i,
  output logic                         mdu_qvalid_o,
  input  wire logic                    mdu_qready_i,
  // FPU response
  input  wire logic                    fpu_pvalid_i,
  input  wire cc_offload_pkg::id_t     fpu_pid_i,
  input  wire cc_offload_pkg::data_t   fpu_pdata_i,
  input  wire logic                    fpu_perror_i,
  output logic                         fpu_pready_o,
  // Muldiv response
  input  wire logic                    mdu_pvalid_i,
  input  wire cc_offload_pkg::id_t     mdu_pid_i,
  input  wire cc_offload_pkg::data_t   mdu_pdata_i,
  input  wire logic                    mdu_perror_i,
  output logic                         mdu_pready_o
);

  acc_req_if core_req ();
  acc_rsp_if core_rsp ();
  // Index 0 FPU, 1 muldiv, 2 SSR config
  acc_req_if tgt_req [cc_offload_pkg::NumTargets] ();
  acc_rsp_if tgt_rsp [cc_offload_pkg::NumTargets] ();

  cc_offload_pkg::cfg_word_t cfg_word;
  logic                      cfg_write;
  cc_offload_pkg::data_t     cfg_wdata;
  cc_offload_pkg::id_t       cfg_rsp_id;
  logic                      regs_we;
  cc_offload_pkg::data_t     regs_rdata;

  // ------------------------------------------------------------
  // Core side
  // ------------------------------------------------------------
  assign core_req.valid  = acc_qvalid_i;
  assign core_req.target = acc_qtarget_i;
  assign core_req.id     = acc_qid_i;
  assign core_req.op     = acc_qop_i;
  assign core_req.arga   = acc_qarga_i;
  assign core_req.argb   = acc_qargb_i;
  assign acc_qready_o    = core_req.ready;

  assign acc_pvalid_o    = core_rsp.valid;
  assign acc_pid_o       = core_rsp.id;
  assign acc_pdata_o     = core_rsp.data;
  assign acc_perror_o    = core_rsp.error;
  assign core_rsp.ready  = acc_pready_i;

  // ------------------------------------------------------------
  // External units, payload is common to all targets
  // ------------------------------------------------------------
  assign ext_qid_o        = tgt_req[0].id;
  assign ext_qop_o        = tgt_req[0].op;
  assign ext_qarga_o      = tgt_req[0].arga;
  assign ext_qargb_o      = tgt_req[0].argb;
  assign fpu_qvalid_o     = tgt_req[0].valid;
  assign tgt_req[0].ready = fpu_qready_i;
  assign mdu_qvalid_o     = tgt_req[1].valid;
  assign tgt_req[1].ready = mdu_qready_i;

  assign tgt_rsp[0].valid = fpu_pvalid_i;
  assign tgt_rsp[0].id    = fpu_pid_i;
  assign tgt_rsp[0].data  = fpu_pdata_i;
  assign tgt_rsp[0].error = fpu_perror_i;
  assign fpu_pready_o     = tgt_rsp[0].ready;
  assign tgt_rsp[1].valid = mdu_pvalid_i;
  assign tgt_rsp[1].id    = mdu_pid_i;
  assign tgt_rsp[1].data  = mdu_pdata_i;
  assign tgt_rsp[1].error = mdu_perror_i;
  assign mdu_pready_o     = tgt_rsp[1].ready;

  offload_router u_offload_router (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .tgt_req  (tgt_req),
    .tgt_rsp  (tgt_rsp)
  );

  // ------------------------------------------------------------
  // SSR configuration unit
  // ------------------------------------------------------------
  ssr_cfg_decode u_ssr_cfg_decode (
    .req_op_i    (tgt_req[2].op),
    .req_id_i    (tgt_req[2].id),
    .req_arga_i  (tgt_req[2].arga),
    .req_argb_i  (tgt_req[2].argb),
    .cfg_word_o  (cfg_word),
    .cfg_write_o (cfg_write),
    .cfg_wdata_o (cfg_wdata),
    .rsp_id_o    (cfg_rsp_id)
  );

  ssr_cfg_ctrl u_ssr_cfg_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ssr_req      (tgt_req[2]),
    .ssr_rsp      (tgt_rsp[2]),
    .cfg_write_i  (cfg_write),
    .rsp_id_i     (cfg_rsp_id),
    .regs_we_o    (regs_we),
    .regs_rdata_i (regs_rdata)
  );

  ssr_cfg_regs u_ssr_cfg_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (regs_we),
    .word_i  (cfg_word),
    .wdata_i (cfg_wdata),
    .rdata_o (regs_rdata)
  );

endmodule

`default_nettype wire

/* hdl/ssr_cfg_regs.sv */
// SSR configuration register bank
// Data movers by registers, unimplemented words read zero

`timescale 1ns/1ps
`default_nettype none

module ssr_cfg_regs (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      we_i,
  input  wire cc_offload_pkg::cfg_word_t word_i,
  input  wire cc_offload_pkg::data_t     wdata_i,
  output cc_offload_pkg::data_t          rdata_o
);

  cc_offload_pkg::data_t regs_q [cc_offload_pkg::NumDataMovers][cc_offload_pkg::NumCfgRegs];

  logic [4:0] dm_sel;
  logic [6:0] reg_sel;

  assign dm_sel  = word_i[11:7];
  assign reg_sel = word_i[6:0];

  // ------------------------------------------------------------
  // Storage, writes outside the bank match no entry
  // ------------------------------------------------------------
  for (genvar dm = 0; dm < cc_offload_pkg::NumDataMovers; dm++) begin : gen_dm
    for (genvar r = 0; r < cc_offload_pkg::NumCfgRegs; r++) begin : gen_reg
      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          regs_q[dm][r] <= '0;
        end else if (we_i && dm_sel == 5'(dm) && reg_sel == 7'(r)) begin
          regs_q[dm][r] <= wdata_i;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    rdata_o = '0;
    for (int dm = 0; dm < cc_offload_pkg::NumDataMovers; dm++) begin
      for (int r = 0; r < cc_offload_pkg::NumCfgRegs; r++) begin
        if (dm_sel == 5'(dm) && reg_sel == 7'(r)) begin
          rdata_o = regs_q[dm][r];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ssr_cfg_ctrl.sv */
// SSR configuration controller
// Accepts config requests, strobes the bank and holds a one-deep
// response buffer toward the router

`timescale 1ns/1ps
`default_nettype none

module ssr_cfg_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  acc_req_if.dst                     ssr_req,
  acc_rsp_if.src                     ssr_rsp,
  input  wire logic                  cfg_write_i,
  input  wire cc_offload_pkg::id_t   rsp_id_i,
  output logic                       regs_we_o,
  input  wire cc_offload_pkg::data_t regs_rdata_i
);

  cc_offload_pkg::cfg_state_e state_q, state_d;
  cc_offload_pkg::id_t        rsp_id_q;
  cc_offload_pkg::data_t      rsp_data_q;
  logic                       req_hs;
  logic                       rsp_hs;

  // Buffer frees up in the same cycle the response leaves
  assign ssr_req.ready = (state_q == cc_offload_pkg::CfgIdle) || ssr_rsp.ready;
  assign req_hs        = ssr_req.valid && ssr_req.ready;
  assign rsp_hs        = ssr_rsp.valid && ssr_rsp.ready;

  assign regs_we_o = req_hs && cfg_write_i;

  always_comb begin
    state_d = state_q;
    if (req_hs) begin
      state_d = cc_offload_pkg::CfgRespPending;
    end else if (rsp_hs) begin
      state_d = cc_offload_pkg::CfgIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cc_offload_pkg::CfgIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Read data is the value before this cycle's write
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_id_q   <= rsp_id_i;
      rsp_data_q <= regs_rdata_i;
    end
  end

  assign ssr_rsp.valid = (state_q == cc_offload_pkg::CfgRespPending);
  assign ssr_rsp.id    = rsp_id_q;
  assign ssr_rsp.data  = rsp_data_q;
  assign ssr_rsp.error = 1'b0;

endmodule

`default_nettype wire

/* hdl/ssr_cfg_decode.sv */
// SSR configuration decoder
// Turns scfg instructions into a bank word index, write flag and data

`timescale 1ns/1ps
`default_nettype none

module ssr_cfg_decode (
  input  wire cc_offload_pkg::instr_t    req_op_i,
  input  wire cc_offload_pkg::id_t       req_id_i,
  input  wire cc_offload_pkg::data_t     req_arga_i,
  input  wire cc_offload_pkg::data_t     req_argb_i,
  output cc_offload_pkg::cfg_word_t      cfg_word_o,
  output logic                           cfg_write_o,
  output cc_offload_pkg::data_t          cfg_wdata_o,
  output cc_offload_pkg::id_t            rsp_id_o
);

  logic [11:0] raw_addr;
  logic [2:0]  funct3;

  assign funct3 = req_op_i[14:12];

  // Immediate forms carry the address in the I-type field,
  // register forms in the low bits of argb
  always_comb begin
    raw_addr    = '0;
    cfg_write_o = 1'b0;
    rsp_id_o    = req_id_i;
    if (req_op_i[6:0] == cc_offload_pkg::ScfgOpcode) begin
      case (funct3)
        cc_offload_pkg::ScfgFunct3Ri: begin
          raw_addr = req_op_i[31:20];
        end
        cc_offload_pkg::ScfgFunct3Wi: begin
          raw_addr    = req_op_i[31:20];
          cfg_write_o = 1'b1;
          rsp_id_o    = '0;
        end
        cc_offload_pkg::ScfgFunct3R: begin
          raw_addr = req_argb_i[11:0];
        end
        cc_offload_pkg::ScfgFunct3W: begin
          raw_addr    = req_argb_i[11:0];
          cfg_write_o = 1'b1;
          // Id zero means no write-back in the core
          rsp_id_o    = '0;
        end
        default: ;
      endcase
    end
  end

  // Data mover from raw [4:0], register from raw [11:5]
  assign cfg_word_o  = {raw_addr[4:0], raw_addr[11:5]};
  assign cfg_wdata_o = req_arga_i;

endmodule

`default_nettype wire

/* hdl/offload_router.sv */
// Offload router
// Steers core requests by target and merges the target responses
// back to the core with a round-robin arbiter

`timescale 1ns/1ps
`default_nettype none

module offload_router (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  acc_req_if.dst    core_req,
  acc_rsp_if.src    core_rsp,
  acc_req_if.src    tgt_req [cc_offload_pkg::NumTargets],
  acc_rsp_if.dst    tgt_rsp [cc_offload_pkg::NumTargets]
);

  logic [cc_offload_pkg::NumTargets-1:0] tgt_ready;
  logic [cc_offload_pkg::NumTargets-1:0] rsp_valid;
  cc_offload_pkg::id_t                   rsp_id    [cc_offload_pkg::NumTargets];
  cc_offload_pkg::data_t                 rsp_data  [cc_offload_pkg::NumTargets];
  logic [cc_offload_pkg::NumTargets-1:0] rsp_error;

  cc_offload_pkg::target_t ptr_q;
  cc_offload_pkg::target_t gnt_d, gnt_q, gnt;
  logic                    lock_q;
  logic                    rsp_hs;

  // ------------------------------------------------------------
  // Request demux
  // ------------------------------------------------------------
  for (genvar i = 0; i < cc_offload_pkg::NumTargets; i++) begin : gen_tgt
    assign tgt_req[i].valid  = core_req.valid &&
                               (core_req.target == cc_offload_pkg::target_t'(i));
    assign tgt_req[i].target = core_req.target;
    assign tgt_req[i].id     = core_req.id;
    assign tgt_req[i].op     = core_req.op;
    assign tgt_req[i].arga   = core_req.arga;
    assign tgt_req[i].argb   = core_req.argb;
    assign tgt_ready[i]      = tgt_req[i].ready;

    assign rsp_valid[i]      = tgt_rsp[i].valid;
    assign rsp_id[i]         = tgt_rsp[i].id;
    assign rsp_data[i]       = tgt_rsp[i].data;
    assign rsp_error[i]      = tgt_rsp[i].error;
    assign tgt_rsp[i].ready  = core_rsp.ready && (gnt == cc_offload_pkg::target_t'(i));
  end

  // Unused target 3 stalls the core forever
  assign core_req.ready = (int'(core_req.target) < cc_offload_pkg::NumTargets) ?
                          tgt_ready[core_req.target] : 1'b0;

  // ------------------------------------------------------------
  // Response arbiter
  // ------------------------------------------------------------
  // First valid source at or after the pointer
  always_comb begin
    int unsigned idx;
    gnt_d = ptr_q;
    for (int i = cc_offload_pkg::NumTargets - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % cc_offload_pkg::NumTargets;
      if (rsp_valid[idx]) begin
        gnt_d = cc_offload_pkg::target_t'(idx);
      end
    end
  end

  // Hold the grant while the core stalls
  assign gnt = lock_q ? gnt_q : gnt_d;

  assign core_rsp.valid = |rsp_valid;
  assign core_rsp.id    = rsp_id[gnt];
  assign core_rsp.data  = rsp_data[gnt];
  assign core_rsp.error = rsp_error[gnt];

  assign rsp_hs = core_rsp.valid && core_rsp.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= core_rsp.valid && !core_rsp.ready;
      gnt_q  <= gnt;
      if (rsp_hs) begin
        ptr_q <= (int'(gnt) == cc_offload_pkg::NumTargets - 1) ? '0 : gnt + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/acc_stream_if.sv */
// Accelerator offload streams
// Request and response channels with valid/ready handshake

`timescale 1ns/1ps
`default_nettype none

// Offload request channel
interface acc_req_if;
  logic                    valid;
  logic                    ready;
  cc_offload_pkg::target_t target;
  cc_offload_pkg::id_t     id;
  cc_offload_pkg::instr_t  op;
  cc_offload_pkg::data_t   arga;
  cc_offload_pkg::data_t   argb;

  modport src (
    output valid, target, id, op, arga, argb,
    input  ready
  );

  modport dst (
    input  valid, target, id, op, arga, argb,
    output ready
  );
endinterface

// Offload response channel
interface acc_rsp_if;
  logic                  valid;
  logic                  ready;
  cc_offload_pkg::id_t   id;
  cc_offload_pkg::data_t data;
  logic                  error;

  modport src (
    output valid, id, data, error,
    input  ready
  );

  modport dst (
    input  valid, id, data, error,
    output ready
  );
endinterface

`default_nettype wire

/* hdl/cc_offload_pkg.sv */
// Offload fabric package
// Shared widths, stream types, SSR config opcodes and bank sizes

`default_nettype none

package cc_offload_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 5;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [31:0]          instr_t;

  // Destination selector, 0 FPU, 1 muldiv, 2 SSR config, 3 unused
  typedef logic [1:0] target_t;

  // Used targets, index 3 is never served
  localparam int unsigned NumTargets = 3;

  // Word index, data mover in [11:7], register in [6:0]
  typedef logic [11:0] cfg_word_t;

  // ------------------------------------------------------------
  // SSR configuration bank
  // ------------------------------------------------------------
  localparam int unsigned NumDataMovers = 2;
  localparam int unsigned NumCfgRegs    = 8;

  // Major opcode and funct3 of the scfg instructions
  localparam logic [6:0] ScfgOpcode   = 7'h2b;
  localparam logic [2:0] ScfgFunct3Ri = 3'd1;
  localparam logic [2:0] ScfgFunct3Wi = 3'd2;
  localparam logic [2:0] ScfgFunct3R  = 3'd3;
  localparam logic [2:0] ScfgFunct3W  = 3'd4;

  // Config controller states
  typedef enum logic {
    CfgIdle,
    CfgRespPending
  } cfg_state_e;

endpackage

`default_nettype wire
